//--- nes_bg_ppu.f
verilog/ppu_pkg.sv
verilog/vga_scan.sv
verilog/ppu_regs.sv
verilog/vram_store.sv
verilog/bg_fetch.sv
verilog/pixel_color.sv
verilog/ppu_top.sv
verif/tb_clock.sv
verif/ppu_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build the testbench with Verilator, run it, then judge the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -Wno-fatal --top-module ppu_tb -f nes_bg_ppu.f -o ppu_sim \
  && ./obj_dir/ppu_sim > sim.log 2>&1 \
  || echo "build or simulation ended with an error"
grep -q "Some tests failed" sim.log && { echo "FAIL"; exit 1; }
grep -q "All tests passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

//--- verif/ppu_tb.sv
/*
 * background picture processor testbench
 * directed tests with a shadow copy of video memory, a pixel reference
 * model and frame capture on the VGA outputs
 */
`timescale 1ns/1ps

module ppu_tb;

  // per-test budget in frames: scan 2, picture 2, attributes 1, mask 3,
  // increment 1, vblank 2, one spare
  localparam longint FRAME_CYCLES = 420000;
  localparam longint WATCHDOG_NS  = (2 + 2 + 1 + 3 + 1 + 2 + 1) * FRAME_CYCLES * 10;

  logic                vga_clk;
  logic                reset;
  ppu_pkg::cpu_wr_t    cpu_wr;
  logic                nmi;
  logic                vga_hs;
  logic                vga_vs;
  logic                vga_de;
  ppu_pkg::rgb_t       vga_rgb;

  // shadow of everything the CPU side has written
  ppu_pkg::byte_t      sh_pat [0:8191];
  ppu_pkg::byte_t      sh_nt  [0:1023];
  ppu_pkg::sys_color_t sh_pal [0:31];
  ppu_pkg::byte_t      sh_ctrl;
  ppu_pkg::ppu_mask_t  sh_mask;
  ppu_pkg::vram_addr_t sh_addr;
  logic                sh_toggle;

  logic   hs_q, vs_q, de_q;
  integer seed;

  tb_clock u_tb_clock (.vga_clk);

  ppu_top u_ppu_top (.vga_clk, .reset, .cpu_wr, .nmi, .vga_hs, .vga_vs, .vga_de, .vga_rgb);

  //////////////////////////////////////////////////////////////////////
  // compare tasks
  task automatic check_rgb(input int x, input int y, input ppu_pkg::rgb_t got,
                           input ppu_pkg::rgb_t exp);
    if (got !== exp) begin
      $display("MISMATCH vga_rgb at drx %0d dry %0d got %h expected %h", x, y, got, exp);
      $display("Some tests failed");
      $fatal(1);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("MISMATCH %s got %h expected %h", name, got, exp);
      $display("Some tests failed");
      $fatal(1);
    end
  endtask

  task automatic check_count(input string name, input ppu_pkg::coord_t got,
                             input ppu_pkg::coord_t exp);
    if (got !== exp) begin
      $display("MISMATCH %s got %h expected %h", name, got, exp);
      $display("Some tests failed");
      $fatal(1);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // one cycle, sampled at the falling edge where outputs are settled
  task automatic tick;
    hs_q = vga_hs;
    vs_q = vga_vs;
    de_q = vga_de;
    @(negedge vga_clk);
  endtask

  task automatic store_shadow(input ppu_pkg::vram_addr_t a, input ppu_pkg::byte_t d);
    ppu_pkg::pal_idx_t idx;
    idx = a[4:0];
    if (a <= 16'h1FFF) begin
      sh_pat[a[12:0]] = d;
    end else if (a <= 16'h3EFF) begin
      sh_nt[a[9:0]] = d;
    end else if (a < 16'h4000) begin
      // 10, 14, 18 and 1C land on 0, 4, 8 and C
      if (idx[4] && idx[1:0] == 2'b00)
        idx[4] = 1'b0;
      sh_pal[idx] = d[5:0];
    end
  endtask

  // one register write with an idle cycle after it
  task automatic write_reg(input ppu_pkg::reg_sel_t sel, input ppu_pkg::byte_t d);
    case (sel)
      ppu_pkg::REG_CTRL: sh_ctrl = d;
      ppu_pkg::REG_MASK: sh_mask = ppu_pkg::ppu_mask_t'(d);
      ppu_pkg::REG_STATUS: sh_toggle = 1'b0;
      ppu_pkg::REG_ADDR: begin
        if (!sh_toggle)
          sh_addr[15:8] = d;
        else
          sh_addr[7:0] = d;
        sh_toggle = ~sh_toggle;
      end
      default: begin
        store_shadow(sh_addr, d);
        sh_addr = sh_addr + (sh_ctrl[2] ? 16'd32 : 16'd1);
      end
    endcase
    @(posedge vga_clk);
    #1;
    cpu_wr.sel  = sel;
    cpu_wr.data = d;
    cpu_wr.we   = 1'b1;
    @(posedge vga_clk);
    #1;
    cpu_wr.we = 1'b0;
  endtask

  task automatic load_vram(input ppu_pkg::vram_addr_t a, input ppu_pkg::byte_t d);
    write_reg(ppu_pkg::REG_ADDR, a[15:8]);
    write_reg(ppu_pkg::REG_ADDR, a[7:0]);
    write_reg(ppu_pkg::REG_DATA, d);
  endtask

  //////////////////////////////////////////////////////////////////////
  // reference model of one VGA pixel
  function automatic ppu_pkg::rgb_t expected_rgb(input int drx, input int dry);
    int x;
    int y;
    int pa;
    int sh;
    ppu_pkg::byte_t tile;
    ppu_pkg::byte_t attr;
    logic [1:0] px;
    logic [1:0] pal;
    x = drx / 2;
    y = dry / 2;
    if (drx >= 512 || !sh_mask.bg_show || (!sh_mask.bg_left && x < 8))
      return '0;
    tile = sh_nt[(y / 8) * 32 + x / 8];
    pa   = sh_ctrl[4] * 4096 + tile * 16 + y % 8;
    px   = {sh_pat[pa + 8][7 - x % 8], sh_pat[pa][7 - x % 8]};
    attr = sh_nt['h3C0 + (y / 32) * 8 + x / 32];
    sh   = ((y / 16) % 2) * 4 + ((x / 16) % 2) * 2;
    pal  = attr[sh +: 2];
    return ppu_pkg::SYS_COLORS[sh_pal[pal * 4 + px]];
  endfunction

  // wait for the next frame and compare every displayed pixel
  task automatic check_frame;
    int x;
    int y;
    x = 0;
    y = 0;
    do tick; while (!(vs_q && !vga_vs));
    while (y < 480) begin
      tick;
      if (vga_de) begin
        check_rgb(x, y, vga_rgb, expected_rgb(x, y));
        x++;
        if (x == 640) begin
          x = 0;
          y++;
        end
      end
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  task automatic test_scan_timing;
    ppu_pkg::coord_t low_cnt, per_cnt, line_cnt, de_lines, de_run;
    low_cnt = 0;
    per_cnt = 0;
    line_cnt = 0;
    de_lines = 0;
    de_run = 0;
    do tick; while (!(hs_q && !vga_hs));
    do begin
      per_cnt++;
      if (!vga_hs)
        low_cnt++;
      tick;
    end while (!(hs_q && !vga_hs));
    check_count("hs_low_cycles", low_cnt, 10'd96);
    check_count("hs_period", per_cnt, 10'd800);
    do tick; while (!(vs_q && !vga_vs));
    do begin
      if (hs_q && !vga_hs)
        line_cnt++;
      if (vga_de) begin
        de_run++;
      end else if (de_q) begin
        check_count("de_width", de_run, 10'd640);
        de_lines++;
        de_run = 0;
      end
      tick;
    end while (!(vs_q && !vga_vs));
    check_count("vs_period_lines", line_cnt, 10'd525);
    check_count("de_lines", de_lines, 10'd480);
  endtask

  task automatic test_full_picture;
    write_reg(ppu_pkg::REG_CTRL, 8'h00);
    write_reg(ppu_pkg::REG_MASK, 8'h0A);
    write_reg(ppu_pkg::REG_ADDR, 8'h00);
    write_reg(ppu_pkg::REG_ADDR, 8'h00);
    for (int i = 0; i < 8192; i++)
      write_reg(ppu_pkg::REG_DATA, ppu_pkg::byte_t'(i * 7 + (i >> 8)));
    // nametable and attributes from the seeded generator
    for (int i = 0; i < 1024; i++)
      write_reg(ppu_pkg::REG_DATA, ppu_pkg::byte_t'($random(seed)));
    load_vram(16'h3F00, 8'h01);
    for (int i = 1; i < 16; i++)
      write_reg(ppu_pkg::REG_DATA, ppu_pkg::byte_t'(i * 3 + 1));
    check_frame;
  endtask

  task automatic test_attr_mirror;
    // each quadrant of a byte gets its own pair
    load_vram(16'h23C0, 8'hE4);
    for (int i = 1; i < 64; i++)
      write_reg(ppu_pkg::REG_DATA, (i < 32) ? 8'hE4 : 8'h1B);
    load_vram(16'h3F10, 8'h2A);
    check_frame;
  endtask

  task automatic test_mask_table;
    write_reg(ppu_pkg::REG_MASK, 8'h00);
    check_frame;
    write_reg(ppu_pkg::REG_MASK, 8'h08);
    check_frame;
    write_reg(ppu_pkg::REG_MASK, 8'h0A);
    write_reg(ppu_pkg::REG_CTRL, 8'h10);
    check_frame;
  endtask

  task automatic test_inc_toggle;
    write_reg(ppu_pkg::REG_CTRL, 8'h04);
    // stray high byte, the status write must discard it
    write_reg(ppu_pkg::REG_ADDR, 8'h3F);
    write_reg(ppu_pkg::REG_STATUS, 8'h00);
    write_reg(ppu_pkg::REG_ADDR, 8'h20);
    write_reg(ppu_pkg::REG_ADDR, 8'h07);
    for (int i = 0; i < 30; i++)
      write_reg(ppu_pkg::REG_DATA, ppu_pkg::byte_t'(8'hC0 + i));
    write_reg(ppu_pkg::REG_CTRL, 8'h00);
    check_frame;
  endtask

  task automatic test_vblank_nmi;
    int falls;
    write_reg(ppu_pkg::REG_STATUS, 8'h00);
    write_reg(ppu_pkg::REG_CTRL, 8'h80);
    do tick; while (!nmi);
    falls = 0;
    do begin
      tick;
      if (hs_q && !vga_hs)
        falls++;
    end while (!(vs_q && !vga_vs));
    check_count("nmi_rise_line", ppu_pkg::coord_t'(ppu_pkg::V_SYNC_START - falls),
                ppu_pkg::VBL_LINE);
    falls = 0;
    do begin
      tick;
      if (hs_q && !vga_hs)
        falls++;
    end while (nmi);
    check_count("nmi_fall_line", ppu_pkg::coord_t'(ppu_pkg::V_SYNC_START + falls),
                ppu_pkg::PRE_LINE);
    do tick; while (!nmi);
    write_reg(ppu_pkg::REG_STATUS, 8'h00);
    check_bit("nmi", nmi, 1'b0);
    write_reg(ppu_pkg::REG_CTRL, 8'h00);
    repeat (FRAME_CYCLES) begin
      tick;
      check_bit("nmi", nmi, 1'b0);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  initial begin
    #(WATCHDOG_NS);
    $display("timeout: the tests did not finish in the allowed time");
    $display("Some tests failed");
    $fatal(1);
  end

  initial begin
    reset = 1'b1;
    cpu_wr = '0;
    seed = 91802;
    sh_ctrl = '0;
    sh_mask = '0;
    sh_addr = '0;
    sh_toggle = 1'b0;
    repeat (8) begin
      @(posedge vga_clk);
      #1;
      check_bit("nmi", nmi, 1'b0);
      check_bit("vga_de", vga_de, 1'b0);
    end
    reset = 1'b0;
    @(posedge vga_clk);
    #1;
    check_bit("nmi", nmi, 1'b0);
    check_bit("vga_de", vga_de, 1'b0);

    test_scan_timing;
    test_full_picture;
    test_attr_mirror;
    test_mask_table;
    test_inc_toggle;
    test_vblank_nmi;

    $display("All tests passed");
    $finish;
  end

endmodule

//--- verif/tb_clock.sv
/*
 * testbench clock source
 * free-running 10 ns vga_clk
 */
`timescale 1ns/1ps

module tb_clock (
  output logic vga_clk
);

  initial begin
    vga_clk = 1'b0;
  end

  always #5 vga_clk = ~vga_clk;

endmodule

//--- verilog/bg_fetch.sv
/*
 * background tile fetch
 * nametable, attribute and plane fetch in 16-cycle groups,
 * then per-pixel plane and attribute selection
 */
`timescale 1ns/1ps

module bg_fetch (
  input  logic                vga_clk,
  input  logic                reset,
  input  ppu_pkg::scan_pos_t  scan,
  input  logic                bg_table,
  output ppu_pkg::nt_addr_t   nt_rd_addr,
  input  ppu_pkg::byte_t      nt_rd_data,
  output ppu_pkg::pat_addr_t  pat_rd_addr,
  input  ppu_pkg::byte_t      pat_rd_data,
  output ppu_pkg::bg_pixel_t  bg_px
);

  logic            fetch_on;
  logic [3:0]      phase;
  logic [4:0]      ndrx;
  logic [7:0]      ndry;
  ppu_pkg::coord_t dry_next;
  ppu_pkg::byte_t  tile_q, attr_q, lo_q, hi_q;
  ppu_pkg::byte_t  attr_d, lo_d, hi_d;
  logic [2:0]      bit_sel;
  logic [2:0]      attr_sh;

  assign phase = scan.drx[3:0];
  assign fetch_on = ((scan.drx < ppu_pkg::IMG_W || scan.drx >= ppu_pkg::PREFETCH_START) &&
                     scan.dry < ppu_pkg::V_VISIBLE) ||
                    (scan.drx >= ppu_pkg::PREFETCH_START && scan.dry == ppu_pkg::PRE_LINE);
  assign dry_next = scan.dry + 10'd1;

  //////////////////////////////////////////////////////////////////////
  // next tile coordinates in source pixels
  always_comb begin
    if (scan.drx[9:4] >= 6'd31) begin
      // past the last tile, start the following line
      ndrx = '0;
      if (scan.dry >= ppu_pkg::V_VISIBLE - 10'd1)
        ndry = '0;
      else
        ndry = dry_next[8:1];
    end else begin
      ndrx = scan.drx[8:4] + 5'd1;
      ndry = scan.dry[8:1];
    end
  end

  // nametable port carries the tile in 0-1 and the attribute in 2-3
  always_comb begin
    if (phase == 4'd2 || phase == 4'd3)
      nt_rd_addr = ppu_pkg::ATTR_BASE | {4'd0, ndry[7:5], ndrx[4:2]};
    else
      nt_rd_addr = {ndry[7:3], ndrx};
  end

  // drx bit 1 separates the low plane (4-5) from the high plane (6-7)
  assign pat_rd_addr = {bg_table, tile_q, scan.drx[1], ndry[2:0]};

  always_ff @(posedge vga_clk) begin
    if (fetch_on) begin
      case (phase)
        4'd1:  tile_q <= nt_rd_data;
        4'd3:  attr_q <= nt_rd_data;
        4'd5:  lo_q   <= pat_rd_data;
        4'd7:  hi_q   <= pat_rd_data;
        4'd15: begin
          attr_d <= attr_q;
          lo_d   <= lo_q;
          hi_d   <= hi_q;
        end
        default: ;
      endcase
    end
  end

  //////////////////////////////////////////////////////////////////////
  // pixel select, leftmost source pixel is plane bit 7
  assign bit_sel = 3'd7 - scan.drx[3:1];
  // quadrant from the 16-pixel halves in source y and x
  assign attr_sh = {scan.dry[5], scan.drx[5], 1'b0};

  always_ff @(posedge vga_clk) begin
    if (reset) begin
      bg_px.pos.drx <= '0;
      bg_px.pos.dry <= '0;
      bg_px.pos.hs  <= 1'b1;
      bg_px.pos.vs  <= 1'b1;
      bg_px.pos.de  <= 1'b0;
      bg_px.px      <= '0;
      bg_px.pal     <= '0;
    end else begin
      bg_px.pos <= scan;
      bg_px.px  <= {hi_d[bit_sel], lo_d[bit_sel]};
      bg_px.pal <= attr_d[attr_sh +: 2];
    end
  end

endmodule

//--- verilog/pixel_color.sv
/*
 * pixel colour stage
 * applies the mask bits, looks up palette and system colour, drives VGA
 */
`timescale 1ns/1ps

module pixel_color (
  input  logic                 vga_clk,
  input  logic                 reset,
  input  ppu_pkg::bg_pixel_t   bg_px,
  input  ppu_pkg::ppu_mask_t   mask,
  output ppu_pkg::pal_idx_t    pal_rd_addr,
  input  ppu_pkg::sys_color_t  pal_rd_data,
  output logic                 vga_hs,
  output logic                 vga_vs,
  output logic                 vga_de,
  output ppu_pkg::rgb_t        vga_rgb
);

  logic          in_img;
  logic          left_col;
  logic          show;
  ppu_pkg::rgb_t rgb_next;

  // image occupies the left 512 columns of the visible area
  assign in_img   = bg_px.pos.de && (bg_px.pos.drx < ppu_pkg::IMG_W);
  // source columns 0 to 7
  assign left_col = bg_px.pos.drx[9:1] < 9'd8;
  assign show     = in_img && mask.bg_show && (mask.bg_left || !left_col);

  assign pal_rd_addr = {1'b0, bg_px.pal, bg_px.px};
  assign rgb_next    = show ? ppu_pkg::SYS_COLORS[pal_rd_data] : '0;

  always_ff @(posedge vga_clk) begin
    if (reset) begin
      vga_hs  <= 1'b1;
      vga_vs  <= 1'b1;
      vga_de  <= 1'b0;
      vga_rgb <= '0;
    end else begin
      vga_hs  <= bg_px.pos.hs;
      vga_vs  <= bg_px.pos.vs;
      vga_de  <= bg_px.pos.de;
      vga_rgb <= rgb_next;
    end
  end

endmodule

//--- verilog/ppu_pkg.sv
/*
 * background picture processor shared definitions
 * scan geometry, video memory map, bus structs and the system colour table
 */
package ppu_pkg;

  typedef logic [9:0]  coord_t;
  typedef logic [15:0] vram_addr_t;
  typedef logic [7:0]  byte_t;
  typedef logic [12:0] pat_addr_t;
  typedef logic [9:0]  nt_addr_t;
  typedef logic [4:0]  pal_idx_t;
  typedef logic [5:0]  sys_color_t;
  // 4 bits each of red, green, blue
  typedef logic [11:0] rgb_t;

  //////////////////////////////////////////////////////////////////////
  // scan geometry, 640x480 at 800x525 total
  localparam coord_t H_TOTAL        = 10'd800;
  localparam coord_t H_SYNC_START   = 10'd656;
  localparam coord_t H_SYNC_END     = 10'd752;
  localparam coord_t H_VISIBLE      = 10'd640;
  localparam coord_t V_TOTAL        = 10'd525;
  localparam coord_t V_SYNC_START   = 10'd490;
  localparam coord_t V_SYNC_END     = 10'd492;
  localparam coord_t V_VISIBLE      = 10'd480;
  localparam coord_t IMG_W          = 10'd512;
  localparam coord_t VBL_LINE       = 10'd480;
  localparam coord_t PRE_LINE       = 10'd524;
  localparam coord_t PREFETCH_START = 10'd768;

  // video memory map
  localparam nt_addr_t   ATTR_BASE  = 10'h3C0;
  localparam vram_addr_t PAT_END    = 16'h1FFF;
  localparam vram_addr_t NT_START   = 16'h2000;
  localparam vram_addr_t NT_END     = 16'h3EFF;
  localparam vram_addr_t PAL_START  = 16'h3F00;
  localparam vram_addr_t INC_ACROSS = 16'd1;
  localparam vram_addr_t INC_DOWN   = 16'd32;

  //////////////////////////////////////////////////////////////////////
  typedef enum logic [2:0] {
    REG_CTRL   = 3'd0,
    REG_MASK   = 3'd1,
    REG_STATUS = 3'd2,
    REG_ADDR   = 3'd6,
    REG_DATA   = 3'd7
  } reg_sel_t;

  typedef struct packed {
    reg_sel_t sel;
    byte_t    data;
    logic     we;
  } cpu_wr_t;

  typedef struct packed {
    coord_t drx;
    coord_t dry;
    logic   hs;
    logic   vs;
    logic   de;
  } scan_pos_t;

  typedef struct packed {
    vram_addr_t addr;
    byte_t      data;
    logic       en;
  } vram_wr_t;

  typedef struct packed {
    scan_pos_t  pos;
    logic [1:0] px;
    logic [1:0] pal;
  } bg_pixel_t;

  // mask register layout, only the background bits are wired up
  typedef struct packed {
    logic emph_b;
    logic emph_g;
    logic emph_r;
    logic spr_show;
    logic bg_show;
    logic spr_left;
    logic bg_left;
    logic grey;
  } ppu_mask_t;

  // system colour index to 12-bit VGA colour
  localparam rgb_t SYS_COLORS [64] = '{
    12'h666, 12'h029, 12'h01C, 12'h30C, 12'h609, 12'h705, 12'h700, 12'h610,
    12'h330, 12'h050, 12'h050, 12'h050, 12'h044, 12'h000, 12'h000, 12'h000,
    12'hAAA, 12'h06F, 12'h34F, 12'h72F, 12'hA2E, 12'hC28, 12'hC30, 12'hA50,
    12'h770, 12'h390, 12'h0A0, 12'h0A3, 12'h089, 12'h000, 12'h000, 12'h000,
    12'hFFF, 12'h5BF, 12'h89F, 12'hB7F, 12'hF7F, 12'hF7C, 12'hF86, 12'hE93,
    12'hBB0, 12'h8D0, 12'h5E4, 12'h4E9, 12'h4DD, 12'h444, 12'h000, 12'h000,
    12'hFFF, 12'hBEF, 12'hCDF, 12'hDCF, 12'hFCF, 12'hFCE, 12'hFCC, 12'hFDB,
    12'hEE9, 12'hCF9, 12'hBFA, 12'hAFC, 12'hAFF, 12'hBBB, 12'h000, 12'h000
  };

endpackage

//--- verilog/ppu_regs.sv
/*
 * CPU-facing register file
 * control, mask, two-write video address, data port and the vblank flag
 */
`timescale 1ns/1ps

module ppu_regs (
  input  logic                vga_clk,
  input  logic                reset,
  input  ppu_pkg::cpu_wr_t    cpu_wr,
  input  ppu_pkg::scan_pos_t  scan,
  output ppu_pkg::vram_wr_t   vram_wr,
  output logic                bg_table,
  output ppu_pkg::ppu_mask_t  mask,
  output logic                nmi
);

  ppu_pkg::byte_t      control;
  ppu_pkg::vram_addr_t vram_addr;
  ppu_pkg::vram_addr_t addr_step;
  logic                toggle;
  logic                incr_pend;
  logic                vbl_flag;
  logic                data_wr;
  logic                vbl_set;
  logic                vbl_clr;

  assign data_wr = cpu_wr.we && (cpu_wr.sel == ppu_pkg::REG_DATA);
  assign vbl_set = (scan.drx == 10'd0) && (scan.dry == ppu_pkg::VBL_LINE);
  assign vbl_clr = (scan.drx == 10'd0) && (scan.dry == ppu_pkg::PRE_LINE);
  // control bit 2 picks the step, across a row or down a column
  assign addr_step = control[2] ? ppu_pkg::INC_DOWN : ppu_pkg::INC_ACROSS;

  always_ff @(posedge vga_clk) begin
    if (reset) begin
      control   <= '0;
      mask      <= '0;
      vram_addr <= '0;
      toggle    <= 1'b0;
      incr_pend <= 1'b0;
      vbl_flag  <= 1'b0;
    end else begin
      // address moves on the edge after the data write
      incr_pend <= data_wr;
      if (incr_pend)
        vram_addr <= vram_addr + addr_step;

      if (cpu_wr.we) begin
        case (cpu_wr.sel)
          ppu_pkg::REG_CTRL: control <= cpu_wr.data;
          ppu_pkg::REG_MASK: mask <= ppu_pkg::ppu_mask_t'(cpu_wr.data);
          ppu_pkg::REG_STATUS: toggle <= 1'b0;
          ppu_pkg::REG_ADDR: begin
            toggle <= ~toggle;
            // high byte first, then low byte
            if (!toggle)
              vram_addr[15:8] <= cpu_wr.data;
            else
              vram_addr[7:0] <= cpu_wr.data;
          end
          default: ;
        endcase
      end

      if (cpu_wr.we && cpu_wr.sel == ppu_pkg::REG_STATUS)
        vbl_flag <= 1'b0;
      else if (vbl_set)
        vbl_flag <= 1'b1;
      else if (vbl_clr)
        vbl_flag <= 1'b0;
    end
  end

  always_comb begin
    vram_wr.addr = vram_addr;
    vram_wr.data = cpu_wr.data;
    vram_wr.en   = data_wr;
  end

  assign bg_table = control[4];
  assign nmi      = vbl_flag & control[7];

  // the address step of a data write must land before the next address use
  assert property (@(posedge vga_clk) disable iff (reset)
    (cpu_wr.we && (cpu_wr.sel == ppu_pkg::REG_DATA || cpu_wr.sel == ppu_pkg::REG_ADDR))
      |-> !incr_pend)
    else $error("video address used before the previous data write stepped it");

endmodule

//--- verilog/ppu_top.sv
/*
 * background picture processor top level
 * scan, registers, video memory, tile fetch and colour output
 */
`timescale 1ns/1ps

module ppu_top (
  input  logic              vga_clk,
  input  logic              reset,
  input  ppu_pkg::cpu_wr_t  cpu_wr,
  output logic              nmi,
  output logic              vga_hs,
  output logic              vga_vs,
  output logic              vga_de,
  output ppu_pkg::rgb_t     vga_rgb
);

  ppu_pkg::scan_pos_t  scan;
  ppu_pkg::vram_wr_t   vram_wr;
  ppu_pkg::ppu_mask_t  mask;
  ppu_pkg::nt_addr_t   nt_rd_addr;
  ppu_pkg::byte_t      nt_rd_data;
  ppu_pkg::pat_addr_t  pat_rd_addr;
  ppu_pkg::byte_t      pat_rd_data;
  ppu_pkg::pal_idx_t   pal_rd_addr;
  ppu_pkg::sys_color_t pal_rd_data;
  ppu_pkg::bg_pixel_t  bg_px;
  logic                bg_table;

  vga_scan u_vga_scan (.vga_clk, .reset, .scan);

  ppu_regs u_ppu_regs (.vga_clk, .reset, .cpu_wr, .scan, .vram_wr, .bg_table, .mask, .nmi);

  vram_store u_vram_store (.vga_clk, .vram_wr, .nt_rd_addr, .nt_rd_data,
                           .pat_rd_addr, .pat_rd_data, .pal_rd_addr, .pal_rd_data);

  bg_fetch u_bg_fetch (.vga_clk, .reset, .scan, .bg_table, .nt_rd_addr, .nt_rd_data,
                       .pat_rd_addr, .pat_rd_data, .bg_px);

  pixel_color u_pixel_color (.vga_clk, .reset, .bg_px, .mask, .pal_rd_addr, .pal_rd_data,
                             .vga_hs, .vga_vs, .vga_de, .vga_rgb);

endmodule

//--- verilog/vga_scan.sv
/*
 * VGA scan generator
 * walks the 800x525 raster and decodes sync and display enable
 */
`timescale 1ns/1ps

module vga_scan (
  input  logic                vga_clk,
  input  logic                reset,
  output ppu_pkg::scan_pos_t  scan
);

  ppu_pkg::coord_t drx;
  ppu_pkg::coord_t dry;

  always_ff @(posedge vga_clk) begin
    if (reset) begin
      drx <= '0;
      dry <= '0;
    end else if (drx == ppu_pkg::H_TOTAL - 10'd1) begin
      drx <= '0;
      // end of line, step to the next one or wrap the frame
      if (dry == ppu_pkg::V_TOTAL - 10'd1)
        dry <= '0;
      else
        dry <= dry + 10'd1;
    end else begin
      drx <= drx + 10'd1;
    end
  end

  // sync pulses are active low
  always_comb begin
    scan.drx = drx;
    scan.dry = dry;
    scan.hs  = !(drx >= ppu_pkg::H_SYNC_START && drx < ppu_pkg::H_SYNC_END);
    scan.vs  = !(dry >= ppu_pkg::V_SYNC_START && dry < ppu_pkg::V_SYNC_END);
    scan.de  = (drx < ppu_pkg::H_VISIBLE) && (dry < ppu_pkg::V_VISIBLE);
  end

  assert property (@(posedge vga_clk) disable iff (reset)
    (drx < ppu_pkg::H_TOTAL) && (dry < ppu_pkg::V_TOTAL))
    else $error("scan counter left the raster");

endmodule

//--- verilog/vram_store.sv
/*
 * video memory
 * pattern RAM, one nametable and the palette, with the palette mirror
 */
`timescale 1ns/1ps

module vram_store (
  input  logic                 vga_clk,
  input  ppu_pkg::vram_wr_t    vram_wr,
  input  ppu_pkg::nt_addr_t    nt_rd_addr,
  output ppu_pkg::byte_t       nt_rd_data,
  input  ppu_pkg::pat_addr_t   pat_rd_addr,
  output ppu_pkg::byte_t       pat_rd_data,
  input  ppu_pkg::pal_idx_t    pal_rd_addr,
  output ppu_pkg::sys_color_t  pal_rd_data
);

  ppu_pkg::byte_t      pat_mem [0:ppu_pkg::PAT_END];
  ppu_pkg::byte_t      nt_mem  [0:1023];
  ppu_pkg::sys_color_t pal_mem [0:31];

  logic              pat_we;
  logic              nt_we;
  logic              pal_we;
  ppu_pkg::pal_idx_t pal_waddr;

  // region decode of the write address
  assign pat_we = vram_wr.en && (vram_wr.addr <= ppu_pkg::PAT_END);
  assign nt_we  = vram_wr.en && (vram_wr.addr >= ppu_pkg::NT_START) &&
                  (vram_wr.addr <= ppu_pkg::NT_END);
  assign pal_we = vram_wr.en && (vram_wr.addr >= ppu_pkg::PAL_START) &&
                  (vram_wr.addr[15:14] == 2'b00);

  // entries 10, 14, 18 and 1C alias the background copies
  always_comb begin
    pal_waddr = vram_wr.addr[4:0];
    if (vram_wr.addr[4] && vram_wr.addr[1:0] == 2'b00)
      pal_waddr[4] = 1'b0;
  end

  always_ff @(posedge vga_clk) begin
    if (pat_we)
      pat_mem[vram_wr.addr[12:0]] <= vram_wr.data;
    if (nt_we)
      nt_mem[vram_wr.addr[9:0]] <= vram_wr.data;
    if (pal_we)
      pal_mem[pal_waddr] <= vram_wr.data[5:0];
  end

  // render-side ports, one cycle for pattern and nametable
  always_ff @(posedge vga_clk) begin
    pat_rd_data <= pat_mem[pat_rd_addr];
    nt_rd_data  <= nt_mem[nt_rd_addr];
  end

  // palette is read in the same cycle
  assign pal_rd_data = pal_mem[pal_rd_addr];

endmodule
